/* Bender.yml */
package:
  name: mini_mcu

sources:
  # packages first, then the blocks and the top level
  - design/mcu_mem_map_pkg.sv
  - design/mcu_irq_pkg.sv
  - design/mcu_bus_decoder.sv
  - design/ao_peripheral_block.sv
  - design/peripheral_block.sv
  - design/irq_assembler.sv
  - design/mini_mcu_top.sv
  - target: simulation
    files:
      - verification/mini_mcu_tb.sv

/* design/ao_peripheral_block.sv */
//********************************************************************
// always-on block, low gpio bank with rising edge interrupts
// and the machine timer
//********************************************************************

`timescale 1ns/1ps

module ao_peripheral_block #(
  parameter int NUM_AO_GPIO = 8
) (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   req_i,
  input  logic                   we_i,
  input  logic [15:0]            offset_i,
  input  logic [31:0]            wdata_i,
  input  logic [NUM_AO_GPIO-1:0] gpio_i,
  output logic [31:0]            rdata_o,
  output logic [NUM_AO_GPIO-1:0] gpio_o,
  output logic [NUM_AO_GPIO-1:0] gpio_oe_o,
  output logic [NUM_AO_GPIO-1:0] gpio_intr_o,
  output logic                   timer_intr_o
);

  logic [NUM_AO_GPIO-1:0] gpio_out_q;
  logic [NUM_AO_GPIO-1:0] gpio_oe_q;
  logic [NUM_AO_GPIO-1:0] intr_en_q;
  logic [NUM_AO_GPIO-1:0] gpio_in_q;
  logic [NUM_AO_GPIO-1:0] gpio_prev_q;
  logic [NUM_AO_GPIO-1:0] gpio_intr_q;
  logic [31:0]            mtime_q;
  logic [31:0]            mtimecmp_q;
  logic                   wr_en;

  assign wr_en = req_i && we_i;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
      intr_en_q  <= '0;
      mtime_q    <= '0;
      mtimecmp_q <= '1;
    end else begin
      // mtime keeps counting unless software loads it
      mtime_q <= mtime_q + 32'd1;
      if (wr_en) begin
        case (offset_i)
          mcu_mem_map_pkg::OFS_GPIO_OUT:     gpio_out_q <= wdata_i[NUM_AO_GPIO-1:0];
          mcu_mem_map_pkg::OFS_GPIO_OE:      gpio_oe_q  <= wdata_i[NUM_AO_GPIO-1:0];
          mcu_mem_map_pkg::OFS_GPIO_INTR_EN: intr_en_q  <= wdata_i[NUM_AO_GPIO-1:0];
          mcu_mem_map_pkg::OFS_MTIME:        mtime_q    <= wdata_i;
          mcu_mem_map_pkg::OFS_MTIMECMP:     mtimecmp_q <= wdata_i;
          default: ;
        endcase
      end
    end
  end

  // input sampling and edge detect, pin to pulse in two cycles
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_in_q   <= '0;
      gpio_prev_q <= '0;
      gpio_intr_q <= '0;
    end else begin
      gpio_in_q   <= gpio_i;
      gpio_prev_q <= gpio_in_q;
      gpio_intr_q <= gpio_in_q & ~gpio_prev_q & intr_en_q;
    end
  end

  always_comb begin
    case (offset_i)
      mcu_mem_map_pkg::OFS_GPIO_OUT:     rdata_o = 32'(gpio_out_q);
      mcu_mem_map_pkg::OFS_GPIO_OE:      rdata_o = 32'(gpio_oe_q);
      mcu_mem_map_pkg::OFS_GPIO_IN:      rdata_o = 32'(gpio_in_q);
      mcu_mem_map_pkg::OFS_GPIO_INTR_EN: rdata_o = 32'(intr_en_q);
      mcu_mem_map_pkg::OFS_MTIME:        rdata_o = mtime_q;
      mcu_mem_map_pkg::OFS_MTIMECMP:     rdata_o = mtimecmp_q;
      default:                           rdata_o = '0;
    endcase
  end

  assign gpio_o       = gpio_out_q;
  assign gpio_oe_o    = gpio_oe_q;
  assign gpio_intr_o  = gpio_intr_q;
  // level, stays up until mtimecmp is moved past mtime
  assign timer_intr_o = (mtime_q >= mtimecmp_q);

  mtime_counts: assert property (@(posedge clk_i) disable iff (reset_i)
    !(wr_en && offset_i == mcu_mem_map_pkg::OFS_MTIME) |=>
    (mtime_q == $past(mtime_q) + 32'd1))
    else $error("mtime did not advance by one without a write");

endmodule

/* design/irq_assembler.sv */
//********************************************************************
// interrupt assembler, latches the fast gpio pulses and builds
// the interrupt vector with acknowledge by id
//********************************************************************

`timescale 1ns/1ps

module irq_assembler #(
  parameter int NUM_AO_GPIO = 8
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic [NUM_AO_GPIO-1:0]               gpio_ao_intr_i,
  input  logic                                 timer_intr_i,
  input  logic                                 ext_intr_i,
  input  logic                                 msip_i,
  input  logic                                 irq_ack_i,
  input  logic [mcu_irq_pkg::IRQ_ID_WIDTH-1:0] irq_id_i,
  output logic [mcu_irq_pkg::IRQ_WIDTH-1:0]    intr_o
);

  // vector index of always-on gpio 0
  localparam int GPIO_VEC_BASE = mcu_irq_pkg::IRQ_FAST_BASE + mcu_irq_pkg::FAST_GPIO_AO_BASE;

  logic [NUM_AO_GPIO-1:0] pending_q;

  // a new pulse beats an acknowledge in the same cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      pending_q <= '0;
    end else begin
      for (int k = 0; k < NUM_AO_GPIO; k++) begin
        if (gpio_ao_intr_i[k]) begin
          pending_q[k] <= 1'b1;
        end else if (irq_ack_i && int'(irq_id_i) == GPIO_VEC_BASE + k) begin
          pending_q[k] <= 1'b0;
        end
      end
    end
  end

  always_comb begin
    intr_o = '0;
    intr_o[mcu_irq_pkg::IRQ_SOFTWARE] = msip_i;
    intr_o[mcu_irq_pkg::IRQ_TIMER]    = timer_intr_i;
    intr_o[mcu_irq_pkg::IRQ_EXTERNAL] = ext_intr_i;
    intr_o[GPIO_VEC_BASE +: NUM_AO_GPIO] = pending_q;
  end

  for (genvar k = 0; k < NUM_AO_GPIO; k++) begin : g_pend_chk
    pend_after_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(pending_q[k]) |-> $past(gpio_ao_intr_i[k]))
      else $error("fast pending bit %0d set without a gpio pulse", k);
  end

endmodule

/* design/mcu_bus_decoder.sv */
//********************************************************************
// register bus decoder that routes requests to the always-on or
// peripheral region and returns registered read data with rvalid
//********************************************************************

`timescale 1ns/1ps

module mcu_bus_decoder (
  input  logic        clk_i,
  input  logic        reset_i,
  input  logic        bus_req_i,
  input  logic        bus_we_i,
  input  logic [31:0] bus_addr_i,
  input  logic [31:0] bus_wdata_i,
  input  logic [31:0] ao_rdata_i,
  input  logic [31:0] periph_rdata_i,
  output logic        bus_rvalid_o,
  output logic [31:0] bus_rdata_o,
  output logic        ao_req_o,
  output logic        periph_req_o,
  output logic        we_o,
  output logic [15:0] offset_o,
  output logic [31:0] wdata_o
);

  mcu_mem_map_pkg::mcu_addr_u bus_addr;

  assign bus_addr.raw = bus_addr_i;

  // region select
  assign ao_req_o     = bus_req_i &&
                        (bus_addr.fields.region == mcu_mem_map_pkg::REGION_AO_PERIPH);
  assign periph_req_o = bus_req_i &&
                        (bus_addr.fields.region == mcu_mem_map_pkg::REGION_PERIPH);

  assign we_o     = bus_we_i;
  assign offset_o = bus_addr.fields.offset;
  assign wdata_o  = bus_wdata_i;

  // every request is answered on the next cycle
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      bus_rvalid_o <= 1'b0;
    end else begin
      bus_rvalid_o <= bus_req_i;
    end
  end

  // writes and unmapped reads return zero
  always_ff @(posedge clk_i) begin
    if (!bus_req_i || bus_we_i) begin
      bus_rdata_o <= '0;
    end else if (ao_req_o) begin
      bus_rdata_o <= ao_rdata_i;
    end else if (periph_req_o) begin
      bus_rdata_o <= periph_rdata_i;
    end else begin
      bus_rdata_o <= '0;
    end
  end

  rvalid_follows_req: assert property (@(posedge clk_i) disable iff (reset_i)
    !$past(reset_i) |-> (bus_rvalid_o == $past(bus_req_i)))
    else $error("rvalid does not match the request of the previous cycle");

endmodule

/* design/mcu_irq_pkg.sv */
//********************************************************************
// interrupt vector layout of the mini MCU
//********************************************************************

package mcu_irq_pkg;

  localparam int IRQ_WIDTH    = 32;
  localparam int IRQ_ID_WIDTH = 5;

  // standard machine interrupt positions
  localparam int IRQ_SOFTWARE = 3;
  localparam int IRQ_TIMER    = 7;
  localparam int IRQ_EXTERNAL = 11;

  // fast interrupts start here
  localparam int IRQ_FAST_BASE = 16;

  // always-on gpio k lands on vector bit 22+k
  localparam int FAST_GPIO_AO_BASE = 6;

endpackage

/* design/mcu_mem_map_pkg.sv */
//********************************************************************
// memory map of the mini MCU peripheral regions
// region codes, register offsets and the bus address view
//********************************************************************

package mcu_mem_map_pkg;

  // region field values, upper half of the bus address
  localparam logic [15:0] REGION_AO_PERIPH = 16'h2000;
  localparam logic [15:0] REGION_PERIPH    = 16'h3000;

  // gpio register offsets, same in both banks
  localparam logic [15:0] OFS_GPIO_OUT     = 16'h0000;
  localparam logic [15:0] OFS_GPIO_OE      = 16'h0004;
  localparam logic [15:0] OFS_GPIO_IN      = 16'h0008;
  localparam logic [15:0] OFS_GPIO_INTR_EN = 16'h000C;

  // machine timer, always-on block only
  localparam logic [15:0] OFS_MTIME        = 16'h0010;
  localparam logic [15:0] OFS_MTIMECMP     = 16'h0014;

  // software interrupt, peripheral block only
  localparam logic [15:0] OFS_MSIP         = 16'h0010;

  // one bus address, either as a raw word or split by region
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [15:0] region;
      logic [15:0] offset;
    } fields;
  } mcu_addr_u;

endpackage

/* design/mini_mcu_top.sv */
//********************************************************************
// mini MCU top level, bus decoder, both peripheral blocks and
// the interrupt assembler joined to the pins
//********************************************************************

`timescale 1ns/1ps

module mini_mcu_top #(
  parameter int NUM_AO_GPIO = 8,
  parameter int NUM_GPIO    = 24
) (
  input  logic                                 clk_i,
  input  logic                                 reset_i,
  input  logic                                 bus_req_i,
  input  logic                                 bus_we_i,
  input  logic [31:0]                          bus_addr_i,
  input  logic [31:0]                          bus_wdata_i,
  output logic                                 bus_rvalid_o,
  output logic [31:0]                          bus_rdata_o,
  input  logic [NUM_AO_GPIO+NUM_GPIO-1:0]      gpio_i,
  output logic [NUM_AO_GPIO+NUM_GPIO-1:0]      gpio_o,
  output logic [NUM_AO_GPIO+NUM_GPIO-1:0]      gpio_oe_o,
  input  logic                                 irq_ack_i,
  input  logic [mcu_irq_pkg::IRQ_ID_WIDTH-1:0] irq_id_i,
  output logic [mcu_irq_pkg::IRQ_WIDTH-1:0]    intr_o
);

  localparam int NUM_PINS = NUM_AO_GPIO + NUM_GPIO;

  logic                   ao_req;
  logic                   periph_req;
  logic                   we;
  logic [15:0]            offset;
  logic [31:0]            wdata;
  logic [31:0]            ao_rdata;
  logic [31:0]            periph_rdata;
  logic [NUM_AO_GPIO-1:0] gpio_ao_intr;
  logic                   timer_intr;
  logic                   ext_intr;
  logic                   msip;

  mcu_bus_decoder u_bus_decoder (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .bus_req_i      (bus_req_i),
    .bus_we_i       (bus_we_i),
    .bus_addr_i     (bus_addr_i),
    .bus_wdata_i    (bus_wdata_i),
    .ao_rdata_i     (ao_rdata),
    .periph_rdata_i (periph_rdata),
    .bus_rvalid_o   (bus_rvalid_o),
    .bus_rdata_o    (bus_rdata_o),
    .ao_req_o       (ao_req),
    .periph_req_o   (periph_req),
    .we_o           (we),
    .offset_o       (offset),
    .wdata_o        (wdata)
  );

  // low pins belong to the always-on bank
  ao_peripheral_block #(
    .NUM_AO_GPIO (NUM_AO_GPIO)
  ) u_ao_peripheral_block (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .req_i        (ao_req),
    .we_i         (we),
    .offset_i     (offset),
    .wdata_i      (wdata),
    .gpio_i       (gpio_i[NUM_AO_GPIO-1:0]),
    .rdata_o      (ao_rdata),
    .gpio_o       (gpio_o[NUM_AO_GPIO-1:0]),
    .gpio_oe_o    (gpio_oe_o[NUM_AO_GPIO-1:0]),
    .gpio_intr_o  (gpio_ao_intr),
    .timer_intr_o (timer_intr)
  );

  // the rest go to the peripheral bank
  peripheral_block #(
    .NUM_GPIO (NUM_GPIO)
  ) u_peripheral_block (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .req_i      (periph_req),
    .we_i       (we),
    .offset_i   (offset),
    .wdata_i    (wdata),
    .gpio_i     (gpio_i[NUM_PINS-1:NUM_AO_GPIO]),
    .rdata_o    (periph_rdata),
    .gpio_o     (gpio_o[NUM_PINS-1:NUM_AO_GPIO]),
    .gpio_oe_o  (gpio_oe_o[NUM_PINS-1:NUM_AO_GPIO]),
    .ext_intr_o (ext_intr),
    .msip_o     (msip)
  );

  irq_assembler #(
    .NUM_AO_GPIO (NUM_AO_GPIO)
  ) u_irq_assembler (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .gpio_ao_intr_i (gpio_ao_intr),
    .timer_intr_i   (timer_intr),
    .ext_intr_i     (ext_intr),
    .msip_i         (msip),
    .irq_ack_i      (irq_ack_i),
    .irq_id_i       (irq_id_i),
    .intr_o         (intr_o)
  );

endmodule

/* design/peripheral_block.sv */
//********************************************************************
// peripheral block, high gpio bank, external level interrupt
// and the software interrupt register
//********************************************************************

`timescale 1ns/1ps

module peripheral_block #(
  parameter int NUM_GPIO = 24
) (
  input  logic                clk_i,
  input  logic                reset_i,
  input  logic                req_i,
  input  logic                we_i,
  input  logic [15:0]         offset_i,
  input  logic [31:0]         wdata_i,
  input  logic [NUM_GPIO-1:0] gpio_i,
  output logic [31:0]         rdata_o,
  output logic [NUM_GPIO-1:0] gpio_o,
  output logic [NUM_GPIO-1:0] gpio_oe_o,
  output logic                ext_intr_o,
  output logic                msip_o
);

  logic [NUM_GPIO-1:0] gpio_out_q;
  logic [NUM_GPIO-1:0] gpio_oe_q;
  logic [NUM_GPIO-1:0] intr_en_q;
  logic [NUM_GPIO-1:0] gpio_in_q;
  logic                msip_q;

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
      intr_en_q  <= '0;
      gpio_in_q  <= '0;
      msip_q     <= 1'b0;
    end else begin
      gpio_in_q <= gpio_i;
      if (req_i && we_i) begin
        case (offset_i)
          mcu_mem_map_pkg::OFS_GPIO_OUT:     gpio_out_q <= wdata_i[NUM_GPIO-1:0];
          mcu_mem_map_pkg::OFS_GPIO_OE:      gpio_oe_q  <= wdata_i[NUM_GPIO-1:0];
          mcu_mem_map_pkg::OFS_GPIO_INTR_EN: intr_en_q  <= wdata_i[NUM_GPIO-1:0];
          mcu_mem_map_pkg::OFS_MSIP:         msip_q     <= wdata_i[0];
          default: ;
        endcase
      end
    end
  end

  always_comb begin
    case (offset_i)
      mcu_mem_map_pkg::OFS_GPIO_OUT:     rdata_o = 32'(gpio_out_q);
      mcu_mem_map_pkg::OFS_GPIO_OE:      rdata_o = 32'(gpio_oe_q);
      mcu_mem_map_pkg::OFS_GPIO_IN:      rdata_o = 32'(gpio_in_q);
      mcu_mem_map_pkg::OFS_GPIO_INTR_EN: rdata_o = 32'(intr_en_q);
      mcu_mem_map_pkg::OFS_MSIP:         rdata_o = 32'(msip_q);
      default:                           rdata_o = '0;
    endcase
  end

  assign gpio_o    = gpio_out_q;
  assign gpio_oe_o = gpio_oe_q;
  // any enabled pin that is high
  assign ext_intr_o = |(gpio_in_q & intr_en_q);
  assign msip_o     = msip_q;

endmodule

/* mini_mcu.f */
design/mcu_mem_map_pkg.sv
design/mcu_irq_pkg.sv
design/mcu_bus_decoder.sv
design/ao_peripheral_block.sv
design/peripheral_block.sv
design/irq_assembler.sv
design/mini_mcu_top.sv
verification/mini_mcu_tb.sv

/* verification/mini_mcu_tb.sv */
//********************************************************************
// testbench for the mini MCU, drives the register bus and the pins
// and checks the responses against a register model with assertions
//********************************************************************

`timescale 1ns/1ps

module mini_mcu_tb;

  localparam int NUM_AO_GPIO    = 8;
  localparam int NUM_GPIO       = 24;
  localparam int NUM_PINS       = NUM_AO_GPIO + NUM_GPIO;
  localparam int TIMEOUT_CYCLES = 2000;
  // vector bit of always-on gpio 0
  localparam int AO_IRQ_BASE    = 22;
  localparam logic [31:0] AO_BASE = 32'h2000_0000;
  localparam logic [31:0] PE_BASE = 32'h3000_0000;
  localparam logic [31:0] NO_BASE = 32'h4000_0000;

  logic                clk_i;
  logic                reset_i;
  logic                bus_req_i;
  logic                bus_we_i;
  logic [31:0]         bus_addr_i;
  logic [31:0]         bus_wdata_i;
  logic                bus_rvalid_o;
  logic [31:0]         bus_rdata_o;
  logic [NUM_PINS-1:0] gpio_i;
  logic [NUM_PINS-1:0] gpio_o;
  logic [NUM_PINS-1:0] gpio_oe_o;
  logic                irq_ack_i;
  logic [4:0]          irq_id_i;
  logic [31:0]         intr_o;

  // register model, updated one step after the accepting edge
  logic [NUM_AO_GPIO-1:0] ao_out_m;
  logic [NUM_AO_GPIO-1:0] ao_oe_m;
  logic [NUM_AO_GPIO-1:0] ao_en_m;
  logic [NUM_GPIO-1:0]    pe_out_m;
  logic [NUM_GPIO-1:0]    pe_oe_m;
  logic [NUM_GPIO-1:0]    pe_en_m;
  logic                   msip_m;
  logic [31:0]            mtime_v;
  logic [31:0]            mtime_c;
  logic [31:0]            mtimecmp_m;
  logic [31:0]            mtime_m;
  logic                   timer_exp;
  logic                   ext_exp;
  logic [31:0]            exp_rdata_d;
  logic [31:0]            exp_rsp_q;
  logic [NUM_GPIO-1:0]    gpio_hi_q;
  logic [31:0]            cyc;
  integer                 seed;
  int                     error_count;

  mini_mcu_top #(
    .NUM_AO_GPIO (NUM_AO_GPIO),
    .NUM_GPIO    (NUM_GPIO)
  ) DUT (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .bus_req_i    (bus_req_i),
    .bus_we_i     (bus_we_i),
    .bus_addr_i   (bus_addr_i),
    .bus_wdata_i  (bus_wdata_i),
    .bus_rvalid_o (bus_rvalid_o),
    .bus_rdata_o  (bus_rdata_o),
    .gpio_i       (gpio_i),
    .gpio_o       (gpio_o),
    .gpio_oe_o    (gpio_oe_o),
    .irq_ack_i    (irq_ack_i),
    .irq_id_i     (irq_id_i),
    .intr_o       (intr_o)
  );

  always #4 clk_i = ~clk_i;

  // mtime counts from its last load, one per cycle
  assign mtime_m   = mtime_v + (cyc - mtime_c);
  assign timer_exp = (mtime_m >= mtimecmp_m);
  assign ext_exp   = |(gpio_hi_q & pe_en_m);

  always @(posedge clk_i) begin
    exp_rsp_q <= exp_rdata_d;
    gpio_hi_q <= gpio_i[NUM_PINS-1:NUM_AO_GPIO];
  end

  // cycle count and run limit
  always @(posedge clk_i) begin
    cyc <= cyc + 32'd1;
    if (cyc == TIMEOUT_CYCLES) begin
      $display("timeout, the test did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic report_mismatch(input string msg);
    error_count++;
    $display("Fail at %0t: %s", $time, msg);
  endtask

  function automatic logic [31:0] expected_read(input logic [31:0] addr);
    logic [31:0] value;
    value = '0;
    if (addr[31:16] == mcu_mem_map_pkg::REGION_AO_PERIPH) begin
      case (addr[15:0])
        mcu_mem_map_pkg::OFS_GPIO_OUT:     value = 32'(ao_out_m);
        mcu_mem_map_pkg::OFS_GPIO_OE:      value = 32'(ao_oe_m);
        mcu_mem_map_pkg::OFS_GPIO_IN:      value = 32'(gpio_i[NUM_AO_GPIO-1:0]);
        mcu_mem_map_pkg::OFS_GPIO_INTR_EN: value = 32'(ao_en_m);
        mcu_mem_map_pkg::OFS_MTIME:        value = mtime_m;
        mcu_mem_map_pkg::OFS_MTIMECMP:     value = mtimecmp_m;
        default:                           value = '0;
      endcase
    end else if (addr[31:16] == mcu_mem_map_pkg::REGION_PERIPH) begin
      case (addr[15:0])
        mcu_mem_map_pkg::OFS_GPIO_OUT:     value = 32'(pe_out_m);
        mcu_mem_map_pkg::OFS_GPIO_OE:      value = 32'(pe_oe_m);
        mcu_mem_map_pkg::OFS_GPIO_IN:      value = 32'(gpio_i[NUM_PINS-1:NUM_AO_GPIO]);
        mcu_mem_map_pkg::OFS_GPIO_INTR_EN: value = 32'(pe_en_m);
        mcu_mem_map_pkg::OFS_MSIP:         value = 32'(msip_m);
        default:                           value = '0;
      endcase
    end
    return value;
  endfunction

  task automatic update_model(input logic [31:0] addr, input logic [31:0] data);
    if (addr[31:16] == mcu_mem_map_pkg::REGION_AO_PERIPH) begin
      case (addr[15:0])
        mcu_mem_map_pkg::OFS_GPIO_OUT:     ao_out_m = data[NUM_AO_GPIO-1:0];
        mcu_mem_map_pkg::OFS_GPIO_OE:      ao_oe_m  = data[NUM_AO_GPIO-1:0];
        mcu_mem_map_pkg::OFS_GPIO_INTR_EN: ao_en_m  = data[NUM_AO_GPIO-1:0];
        mcu_mem_map_pkg::OFS_MTIME: begin
          mtime_v = data;
          mtime_c = cyc;
        end
        mcu_mem_map_pkg::OFS_MTIMECMP:     mtimecmp_m = data;
        default: ;
      endcase
    end else if (addr[31:16] == mcu_mem_map_pkg::REGION_PERIPH) begin
      case (addr[15:0])
        mcu_mem_map_pkg::OFS_GPIO_OUT:     pe_out_m = data[NUM_GPIO-1:0];
        mcu_mem_map_pkg::OFS_GPIO_OE:      pe_oe_m  = data[NUM_GPIO-1:0];
        mcu_mem_map_pkg::OFS_GPIO_INTR_EN: pe_en_m  = data[NUM_GPIO-1:0];
        mcu_mem_map_pkg::OFS_MSIP:         msip_m   = data[0];
        default: ;
      endcase
    end
  endtask

  // one request, called 1 ns after a rising edge and returns likewise
  task automatic bus_access(input logic we, input logic [31:0] addr, input logic [31:0] data);
    bus_req_i   = 1'b1;
    bus_we_i    = we;
    bus_addr_i  = addr;
    bus_wdata_i = data;
    exp_rdata_d = we ? 32'd0 : expected_read(addr);
    @(posedge clk_i);
    #1;
    if (we) begin
      update_model(addr, data);
    end
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    exp_rdata_d = '0;
  endtask

  task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
    bus_access(1'b1, addr, data);
  endtask

  task automatic read_reg(input logic [31:0] addr);
    bus_access(1'b0, addr, 32'd0);
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
    #1;
  endtask

  task automatic ack_irq(input logic [4:0] id);
    irq_ack_i = 1'b1;
    irq_id_i  = id;
    @(posedge clk_i);
    #1;
    irq_ack_i = 1'b0;
    irq_id_i  = '0;
  endtask

  reset_values: assert property (@(posedge clk_i)
    $fell(reset_i) |-> (gpio_oe_o == '0 && intr_o == '0 && !bus_rvalid_o))
    else report_mismatch("outputs not cleared after reset");

  rvalid_after_req: assert property (@(posedge clk_i) disable iff (reset_i)
    bus_req_i |=> bus_rvalid_o)
    else report_mismatch("no rvalid one cycle after a request");

  no_rvalid_idle: assert property (@(posedge clk_i) disable iff (reset_i)
    !bus_req_i |=> !bus_rvalid_o)
    else report_mismatch("rvalid without a request");

  rdata_matches: assert property (@(posedge clk_i) disable iff (reset_i)
    bus_rvalid_o |-> (bus_rdata_o == exp_rsp_q))
    else report_mismatch($sformatf("read data %h, expected %h", bus_rdata_o, exp_rsp_q));

  pins_out: assert property (@(posedge clk_i) disable iff (reset_i)
    gpio_o == {pe_out_m, ao_out_m})
    else report_mismatch("gpio_o differs from the written out registers");

  pins_oe: assert property (@(posedge clk_i) disable iff (reset_i)
    gpio_oe_o == {pe_oe_m, ao_oe_m})
    else report_mismatch("gpio_oe_o differs from the written oe registers");

  level_irqs: assert property (@(posedge clk_i) disable iff (reset_i)
    intr_o[7] == timer_exp && intr_o[3] == msip_m && intr_o[11] == ext_exp)
    else report_mismatch($sformatf("level interrupts %b, expected timer %b msip %b ext %b",
                         {intr_o[7], intr_o[3], intr_o[11]}, timer_exp, msip_m, ext_exp));

  unused_irqs: assert property (@(posedge clk_i) disable iff (reset_i)
    (intr_o & ~32'h3FC0_0888) == '0)
    else report_mismatch("unused interrupt vector bit set");

  for (genvar k = 0; k < NUM_AO_GPIO; k++) begin : g_ao_irq
    localparam int ID = AO_IRQ_BASE + k;

    edge_sets: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(gpio_i[k]) ##1 ao_en_m[k] |-> ##2 intr_o[ID])
      else report_mismatch($sformatf("enabled edge on gpio %0d did not set bit %0d", k, ID));

    only_enabled_edge: assert property (@(posedge clk_i) disable iff (reset_i)
      $rose(intr_o[ID]) |->
      ($past(gpio_i[k], 3) && !$past(gpio_i[k], 4) && $past(ao_en_m[k], 2)))
      else report_mismatch($sformatf("bit %0d set without an enabled edge", ID));

    stays_set: assert property (@(posedge clk_i) disable iff (reset_i)
      intr_o[ID] && !(irq_ack_i && irq_id_i == ID) |=> intr_o[ID])
      else report_mismatch($sformatf("bit %0d cleared without acknowledge", ID));

    ack_clears: assert property (@(posedge clk_i) disable iff (reset_i)
      irq_ack_i && irq_id_i == ID && !($past(gpio_i[k], 2) && !$past(gpio_i[k], 3))
      |=> !intr_o[ID])
      else report_mismatch($sformatf("acknowledge did not clear bit %0d", ID));
  end

  initial begin
    logic [31:0] data;
    clk_i       = 1'b0;
    reset_i     = 1'b1;
    bus_req_i   = 1'b0;
    bus_we_i    = 1'b0;
    bus_addr_i  = '0;
    bus_wdata_i = '0;
    gpio_i      = '0;
    irq_ack_i   = 1'b0;
    irq_id_i    = '0;
    ao_out_m    = '0;
    ao_oe_m     = '0;
    ao_en_m     = '0;
    pe_out_m    = '0;
    pe_oe_m     = '0;
    pe_en_m     = '0;
    msip_m      = 1'b0;
    mtime_v     = '0;
    mtime_c     = '0;
    mtimecmp_m  = '1;
    exp_rdata_d = '0;
    cyc         = '0;
    seed        = 14;
    error_count = 0;

    repeat (5) @(posedge clk_i);
    #1;
    reset_i = 1'b0;
    mtime_c = cyc;

    // reset values and unmapped accesses
    read_reg(AO_BASE + mcu_mem_map_pkg::OFS_MTIMECMP);
    read_reg(AO_BASE + mcu_mem_map_pkg::OFS_MTIME);
    read_reg(NO_BASE + mcu_mem_map_pkg::OFS_GPIO_OUT);
    write_reg(NO_BASE, 32'hDEAD_BEEF);
    read_reg(AO_BASE + 32'h0020);
    wait_cycles(2);

    // random pin registers in both banks, back to back
    repeat (8) begin
      data = $random(seed);
      write_reg(AO_BASE + mcu_mem_map_pkg::OFS_GPIO_OUT, data);
      data = $random(seed);
      write_reg(AO_BASE + mcu_mem_map_pkg::OFS_GPIO_OE, data);
      data = $random(seed);
      write_reg(PE_BASE + mcu_mem_map_pkg::OFS_GPIO_OUT, data);
      data = $random(seed);
      write_reg(PE_BASE + mcu_mem_map_pkg::OFS_GPIO_OE, data);
      gpio_i = $random(seed);
      wait_cycles(2);
      read_reg(AO_BASE + mcu_mem_map_pkg::OFS_GPIO_IN);
      read_reg(PE_BASE + mcu_mem_map_pkg::OFS_GPIO_IN);
      read_reg(AO_BASE + mcu_mem_map_pkg::OFS_GPIO_OE);
      read_reg(PE_BASE + mcu_mem_map_pkg::OFS_GPIO_OUT);
      wait_cycles(1);
    end
    gpio_i = '0;
    wait_cycles(3);

    // edge interrupts on the always-on bank
    write_reg(AO_BASE + mcu_mem_map_pkg::OFS_GPIO_INTR_EN, 32'h0000_000F);
    read_reg(AO_BASE + mcu_mem_map_pkg::OFS_GPIO_INTR_EN);
    gpio_i[1] = 1'b1;
    wait_cycles(6);
    ack_irq(5'(AO_IRQ_BASE + 2));
    wait_cycles(2);
    ack_irq(5'(AO_IRQ_BASE + 1));
    wait_cycles(2);
    gpio_i[5] = 1'b1;
    wait_cycles(6);
    gpio_i = '0;
    wait_cycles(3);

    // software and external levels
    write_reg(PE_BASE + mcu_mem_map_pkg::OFS_MSIP, 32'h1);
    read_reg(PE_BASE + mcu_mem_map_pkg::OFS_MSIP);
    wait_cycles(3);
    write_reg(PE_BASE + mcu_mem_map_pkg::OFS_MSIP, 32'h0);
    write_reg(PE_BASE + mcu_mem_map_pkg::OFS_GPIO_INTR_EN, 32'h0000_0100);
    gpio_i[NUM_AO_GPIO + 8] = 1'b1;
    wait_cycles(3);
    gpio_i[NUM_AO_GPIO + 8] = 1'b0;
    wait_cycles(3);

    // machine timer reaches its compare value
    write_reg(AO_BASE + mcu_mem_map_pkg::OFS_MTIME, 32'h0000_1000);
    write_reg(AO_BASE + mcu_mem_map_pkg::OFS_MTIMECMP, 32'h0000_1000 + 32'd30);
    wait_cycles(40);
    read_reg(AO_BASE + mcu_mem_map_pkg::OFS_MTIME);
    write_reg(AO_BASE + mcu_mem_map_pkg::OFS_MTIMECMP, 32'hFFFF_FFFF);
    wait_cycles(4);

    $display("checks failed: %0d", error_count);
    if (error_count == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule
